//--- hdl/sms_defines.svh
//============================
// Widths, divider period and download indexes for the cart loader
// Include in every RTL file that needs them
//============================
`ifndef SMS_DEFINES_SVH
`define SMS_DEFINES_SVH

// Bus widths
`define SMS_IOCTL_AW 25   // Host download address
`define SMS_ROM_AW 22     // Console ROM read address
`define SMS_ROMWR_AW 24   // External ROM write address

// Clock enable cycle in clk_sys ticks
`define SMS_CE_PERIOD 30

// Copier header in front of some images
`define SMS_HDR_BYTES 512

// Download indexes
`define SMS_CODE_INDEX 8'hFF   // Cheat code data
`define SMS_GG_INDEX 5'd2      // Game Gear image, low five bits

`endif

//--- hdl/sms_pkg.sv
//============================
// Shared bus and code word types of the cart loader
//============================
`include "sms_defines.svh"

package sms_pkg;

	// One beat of the host download stream
	typedef struct packed {
		logic                     wr;
		logic [`SMS_IOCTL_AW-1:0] addr;
		logic [7:0]               dout;
		logic                     download;
		logic [7:0]               index;
	} ioctl_t;

	// Console clock enables
	typedef struct packed {
		logic cpu;
		logic vdp;
		logic pix;
		logic sp;
	} ce_t;

	// ROM write request, toggle handshaked
	typedef struct packed {
		logic                     req;
		logic [`SMS_ROMWR_AW-1:0] addr;
		logic [7:0]               data;
	} rom_wr_t;

	typedef struct packed {
		logic [31:0] flags;    // Highest word
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Filled byte by byte, read field by field
	typedef union packed {
		cheat_fields_t   fields;
		logic [15:0][7:0] bytes;
	} cheat_code_u;

endpackage

//--- hdl/clk_enable_gen.sv
//============================
// Divides clk_sys into CPU, VDP, pixel and sprite enables
//============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module clk_enable_gen (
	input  logic              clk_sys,
	input  logic              arst_n_i,
	output sms_pkg::ce_t      ce_o
);

	localparam int CNT_W = $clog2(`SMS_CE_PERIOD);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SMS_CE_PERIOD - 1);

	logic [CNT_W-1:0] cnt;
	sms_pkg::ce_t     ce_nxt;
	sms_pkg::ce_t     ce_q;

	// Enable table per count
	always_comb begin
		ce_nxt     = '0;
		ce_nxt.sp  = cnt[0];                              // Every other tick
		ce_nxt.vdp = ((cnt % CNT_W'(5)) == CNT_W'(4));    // Every fifth tick
		ce_nxt.pix = ((cnt % CNT_W'(10)) == CNT_W'(9));   // Every tenth tick
		case (cnt)
			CNT_W'(9):  ce_nxt.cpu = 1'b1;
			CNT_W'(24): ce_nxt.cpu = 1'b1;   // CPU phase placed late in the cycle
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cnt  <= '0;
			ce_q <= '0;
		end else begin
			cnt  <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
			ce_q <= ce_nxt;
		end
	end

	assign ce_o = ce_q;

	// CPU steps only on a VDP slot
	a_cpu_on_vdp: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		ce_q.cpu |-> ce_q.vdp)
		else $error("ce cpu without ce vdp");

endmodule

//--- hdl/rom_write_ctrl.sv
//============================
// Cartridge bytes to ROM writes over a toggle req/ack pair
// Holds the host with wait_o until each write is acknowledged
//============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module rom_write_ctrl (
	input  logic              clk_sys,
	input  logic              arst_n_i,
	input  sms_pkg::ioctl_t   ioctl_i,
	input  logic              cart_dl_i,
	output logic              wait_o,
	output sms_pkg::rom_wr_t  rom_wr_o,
	input  logic              rom_ack_i
);

	logic                     cart_dl_q;
	logic [`SMS_ROMWR_AW-1:0] wr_addr;
	logic                     req_q;
	logic                     wait_q;
	logic [7:0]               data_q;

	logic dl_start;
	logic wr_beat;
	logic ack_done;

	assign dl_start = cart_dl_i && !cart_dl_q;
	assign wr_beat  = ioctl_i.wr && cart_dl_i;
	assign ack_done = wait_q && (req_q == rom_ack_i);   // Memory caught up

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cart_dl_q <= 1'b0;
			wr_addr   <= '0;
			req_q     <= 1'b0;
			wait_q    <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl_i;

			if (dl_start)
				wr_addr <= '0;   // New image starts at the bottom
			else if (ack_done)
				wr_addr <= wr_addr + 1'b1;

			if (wr_beat) begin
				req_q  <= ~req_q;
				wait_q <= 1'b1;
			end else if (ack_done) begin
				wait_q <= 1'b0;
			end
		end
	end

	// Write byte
	always_ff @(posedge clk_sys) begin
		if (wr_beat)
			data_q <= ioctl_i.dout;
	end

	always_comb begin
		rom_wr_o.req  = req_q;
		rom_wr_o.addr = wr_addr;
		rom_wr_o.data = data_q;
	end

	assign wait_o = wait_q;

	// Host must hold off while a write is pending
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n_i)
		wait_q |-> !wr_beat)
		else $error("download write while wait_o high");

endmodule

//--- hdl/cart_geometry.sv
//============================
// Learns cartridge size masks and copier header from the download
// Maps console ROM reads onto the stored image
//============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module cart_geometry (
	input  logic                   clk_sys,
	input  logic                   arst_n_i,
	input  sms_pkg::ioctl_t        ioctl_i,
	input  logic                   cart_dl_i,
	input  logic [`SMS_ROM_AW-1:0] rom_rd_addr_i,
	output logic [`SMS_ROM_AW-1:0] rom_raddr_o,
	output logic                   is_gg_o,
	output logic                   cart_loaded_o
);

	localparam logic [`SMS_ROM_AW-1:0] HDR_OFS = `SMS_ROM_AW'(`SMS_HDR_BYTES);

	logic                   cart_dl_q;
	logic [`SMS_ROM_AW-1:0] cart_mask;
	logic [`SMS_ROM_AW-1:0] hdr_mask;   // Mask of the image behind a header
	logic                   hdr_flag;
	logic                   is_gg;
	logic                   loaded;

	logic                   beat;
	logic                   dl_end;
	logic [`SMS_ROM_AW-1:0] beat_addr;

	assign beat      = ioctl_i.wr && cart_dl_i;
	assign dl_end    = cart_dl_q && !cart_dl_i;
	assign beat_addr = ioctl_i.addr[`SMS_ROM_AW-1:0];

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cart_dl_q <= 1'b0;
			cart_mask <= '0;
			hdr_mask  <= '0;
			hdr_flag  <= 1'b0;
			is_gg     <= 1'b0;
			loaded    <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl_i;

			if (beat) begin
				// Highest address bits seen so far
				if (ioctl_i.addr == '0)
					cart_mask <= '0;
				else
					cart_mask <= cart_mask | beat_addr;

				if (ioctl_i.addr == `SMS_IOCTL_AW'(`SMS_HDR_BYTES))
					hdr_mask <= '0;
				else
					hdr_mask <= hdr_mask | (beat_addr - HDR_OFS);

				is_gg  <= (ioctl_i.index[4:0] == `SMS_GG_INDEX);
				loaded <= 1'b1;   // Sticky until reset
			end

			// Host leaves addr at the byte count when done
			if (dl_end)
				hdr_flag <= ioctl_i.addr[9];
		end
	end

	// ROM read translation
	always_comb begin
		if (hdr_flag)
			rom_raddr_o = (rom_rd_addr_i + HDR_OFS) & hdr_mask;   // Skip header
		else
			rom_raddr_o = rom_rd_addr_i & cart_mask;
	end

	assign is_gg_o       = is_gg;
	assign cart_loaded_o = loaded;

endmodule

//--- hdl/cheat_code_loader.sv
//============================
// Builds one cheat code word from 16 downloaded bytes
//============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  arst_n_i,
	input  sms_pkg::ioctl_t       ioctl_i,
	input  logic                  code_dl_i,
	output sms_pkg::cheat_code_u  cheat_o,
	output logic                  code_valid_o
);

	sms_pkg::cheat_code_u code_q;
	logic                 valid_q;

	logic       beat;
	logic [3:0] ofs;
	logic [3:0] lane;

	assign beat = ioctl_i.wr && code_dl_i;
	assign ofs  = ioctl_i.addr[3:0];

	// Offset to byte lane of the word
	// Field order flips since flags sit on top, byte order within a field stays
	assign lane = {~ofs[3:2], ofs[1:0]};

	always_ff @(posedge clk_sys) begin
		if (beat)
			code_q.bytes[lane] <= ioctl_i.dout;
	end

	always_ff @(posedge clk_sys or negedge arst_n_i) begin
		if (!arst_n_i)
			valid_q <= 1'b0;
		else
			valid_q <= beat && (ofs == 4'hF);   // Last byte of the code
	end

	assign cheat_o      = code_q;
	assign code_valid_o = valid_q;

endmodule

//--- hdl/sms_cart_loader.sv
//============================
// Cart and cheat loading front end with console clock enables
//============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module sms_cart_loader (
	input  logic                   clk_sys,
	input  logic                   arst_n_i,
	input  sms_pkg::ioctl_t        ioctl_i,
	output logic                   wait_o,
	output sms_pkg::rom_wr_t       rom_wr_o,
	input  logic                   rom_ack_i,
	input  logic [`SMS_ROM_AW-1:0] rom_rd_addr_i,
	output logic [`SMS_ROM_AW-1:0] rom_raddr_o,
	output logic                   is_gg_o,
	output logic                   cart_loaded_o,
	output sms_pkg::cheat_code_u   cheat_o,
	output logic                   cheat_valid_o,
	output sms_pkg::ce_t           ce_o
);

	//============================
	// Download type decode
	//============================
	logic code_idx;
	logic cart_dl;
	logic code_dl;

	assign code_idx = (ioctl_i.index == `SMS_CODE_INDEX);
	assign cart_dl  = ioctl_i.download && !code_idx;
	assign code_dl  = ioctl_i.download && code_idx;

	//============================
	// Blocks
	//============================
	clk_enable_gen u_ce (
		.clk_sys  (clk_sys),
		.arst_n_i (arst_n_i),
		.ce_o     (ce_o)
	);

	rom_write_ctrl u_romwr (
		.clk_sys   (clk_sys),
		.arst_n_i  (arst_n_i),
		.ioctl_i   (ioctl_i),
		.cart_dl_i (cart_dl),
		.wait_o    (wait_o),
		.rom_wr_o  (rom_wr_o),
		.rom_ack_i (rom_ack_i)
	);

	cart_geometry u_geom (
		.clk_sys       (clk_sys),
		.arst_n_i      (arst_n_i),
		.ioctl_i       (ioctl_i),
		.cart_dl_i     (cart_dl),
		.rom_rd_addr_i (rom_rd_addr_i),
		.rom_raddr_o   (rom_raddr_o),
		.is_gg_o       (is_gg_o),
		.cart_loaded_o (cart_loaded_o)
	);

	cheat_code_loader u_cheat (
		.clk_sys      (clk_sys),
		.arst_n_i     (arst_n_i),
		.ioctl_i      (ioctl_i),
		.code_dl_i    (code_dl),
		.cheat_o      (cheat_o),
		.code_valid_o (cheat_valid_o)
	);

endmodule

//--- testbench/tb_sms_cart_loader.sv
//============================
// Directed testbench for the cart loader, with an SDRAM ack model
//============================
`timescale 1ns/1ps
`include "sms_defines.svh"

module tb_sms_cart_loader;

	logic                   clk_sys = 1'b0;
	logic                   arst_n_i;
	sms_pkg::ioctl_t        ioctl;
	logic                   wait_o;
	sms_pkg::rom_wr_t       rom_wr;
	logic                   rom_ack_i;
	logic [`SMS_ROM_AW-1:0] rd_addr;
	logic [`SMS_ROM_AW-1:0] raddr;
	logic                   is_gg;
	logic                   loaded;
	sms_pkg::cheat_code_u   cheat;
	logic                   cheat_valid;
	sms_pkg::ce_t           ce;

	int          val_errs = 0;     // Wrong values
	int          proto_errs = 0;   // Handshake timeouts
	logic        aborted = 1'b0;
	logic        exp_req = 1'b0;   // Toggle expected after each cart byte
	logic [15:0] data_lfsr = 16'd60;
	logic [15:0] ack_lfsr = 16'd60;

	always #10 clk_sys = ~clk_sys;

	sms_cart_loader dut (
		.clk_sys       (clk_sys),
		.arst_n_i      (arst_n_i),
		.ioctl_i       (ioctl),
		.wait_o        (wait_o),
		.rom_wr_o      (rom_wr),
		.rom_ack_i     (rom_ack_i),
		.rom_rd_addr_i (rd_addr),
		.rom_raddr_o   (raddr),
		.is_gg_o       (is_gg),
		.cart_loaded_o (loaded),
		.cheat_o       (cheat),
		.cheat_valid_o (cheat_valid),
		.ce_o          (ce)
	);

	//============================
	// Stimulus helpers
	//============================
	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(inout logic [15:0] st, input int n, output logic [7:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			st  = lfsr_step(st);
			val = {val[6:0], st[0]};   // One step per bit
		end
	endtask

	// Next drive slot, 2 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	//============================
	// Compare tasks
	//============================
	task automatic check_ce(input sms_pkg::ce_t got, input sms_pkg::ce_t want);
		if (got !== want) begin
			val_errs++;
			$display("[FAIL] t=%0t ce_o got %b exp %b", $time, got, want);
		end
	endtask

	task automatic check_rom_wr(input sms_pkg::rom_wr_t got, input sms_pkg::rom_wr_t want);
		if (got !== want) begin
			val_errs++;
			$display("[FAIL] t=%0t rom_wr_o got req %b addr %h data %h, exp req %b addr %h data %h",
				$time, got.req, got.addr, got.data, want.req, want.addr, want.data);
		end
	endtask

	task automatic check_addr(input string name, input logic [`SMS_ROM_AW-1:0] got,
		input logic [`SMS_ROM_AW-1:0] want);
		if (got !== want) begin
			val_errs++;
			$display("[FAIL] t=%0t %s got %h exp %h", $time, name, got, want);
		end
	endtask

	task automatic check_cheat(input sms_pkg::cheat_fields_t got,
		input sms_pkg::cheat_fields_t want);
		if (got !== want) begin
			val_errs++;
			$display("[FAIL] t=%0t cheat_o got %h exp %h", $time, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			val_errs++;
			$display("[FAIL] t=%0t %s got %b exp %b", $time, name, got, want);
		end
	endtask

	// SDRAM side, copies req to ack after 1 to 4 cycles
	initial begin : ack_model
		logic [7:0] dly;
		rom_ack_i = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (rom_wr.req !== rom_ack_i) begin
				take_bits(ack_lfsr, 2, dly);
				repeat (int'(dly) + 1) @(posedge clk_sys);
				#2;
				rom_ack_i = rom_wr.req;
			end
		end
	end

	//============================
	// Tests
	//============================
	task automatic count_enables();
		int n_sp = 0;
		int n_vdp = 0;
		int n_pix = 0;
		int n_cpu = 0;
		for (int c = 0; c < 60; c++) begin
			tick();
			n_sp  += int'(ce.sp);
			n_vdp += int'(ce.vdp);
			n_pix += int'(ce.pix);
			n_cpu += int'(ce.cpu);
			if (ce.cpu)
				check_bit("ce_o.vdp", ce.vdp, 1'b1);   // CPU slot is a VDP slot
		end
		if (n_sp != 30 || n_vdp != 12 || n_pix != 6 || n_cpu != 4) begin
			val_errs++;
			$display("[FAIL] t=%0t ce_o counts sp %0d vdp %0d pix %0d cpu %0d, exp 30 12 6 4",
				$time, n_sp, n_vdp, n_pix, n_cpu);
		end
	endtask

	// Cart download, host pauses while wait_o is high
	task automatic load_cart(input logic [7:0] idx, input int nbytes);
		logic [7:0]       b;
		sms_pkg::rom_wr_t want;
		int               t;
		ioctl.download = 1'b1;
		ioctl.index    = idx;
		ioctl.addr     = '0;
		tick();   // Start of download seen before the first byte
		for (int i = 0; i < nbytes && !aborted; i++) begin
			take_bits(data_lfsr, 8, b);
			ioctl.wr   = 1'b1;
			ioctl.addr = `SMS_IOCTL_AW'(i);
			ioctl.dout = b;
			tick();
			ioctl.wr = 1'b0;
			exp_req  = ~exp_req;
			want     = '{req: exp_req, addr: `SMS_ROMWR_AW'(i), data: b};
			check_rom_wr(rom_wr, want);
			check_bit("wait_o", wait_o, 1'b1);
			t = 0;
			while (wait_o && t < 200) begin
				tick();
				t++;
			end
			if (wait_o) begin
				proto_errs++;
				aborted = 1'b1;
				$display("Timeout, wait_o still high 200 cycles after byte %0d", i);
			end else begin
				check_bit("rom_ack_i", rom_ack_i, exp_req);   // Ack came first
			end
		end
		ioctl.download = 1'b0;
		ioctl.addr     = `SMS_IOCTL_AW'(nbytes);   // Host leaves the byte count
		tick();
		tick();
	endtask

	task automatic probe_read(input logic [`SMS_ROM_AW-1:0] a,
		input logic [`SMS_ROM_AW-1:0] want);
		rd_addr = a;
		#1;
		check_addr("rom_raddr_o", raddr, want);
		tick();
	endtask

	task automatic load_cheat();
		logic [7:0]             b [16];
		sms_pkg::cheat_fields_t want;
		ioctl.download = 1'b1;
		ioctl.index    = `SMS_CODE_INDEX;
		for (int k = 0; k < 16; k++) begin
			take_bits(data_lfsr, 8, b[k]);
			ioctl.wr   = 1'b1;
			ioctl.addr = `SMS_IOCTL_AW'(k);
			ioctl.dout = b[k];
			tick();
			check_bit("cheat_valid_o", cheat_valid, k == 15);
			check_bit("wait_o", wait_o, 1'b0);
		end
		ioctl.wr = 1'b0;
		tick();
		check_bit("cheat_valid_o", cheat_valid, 1'b0);   // Single cycle pulse
		// Lower offset lands in the lower byte of a field
		want.flags   = {b[3], b[2], b[1], b[0]};
		want.address = {b[7], b[6], b[5], b[4]};
		want.compare = {b[11], b[10], b[9], b[8]};
		want.replace = {b[15], b[14], b[13], b[12]};
		check_cheat(cheat.fields, want);
		check_bit("rom_wr_o.req", rom_wr.req, exp_req);
		ioctl.download = 1'b0;
		tick();
	endtask

	initial begin
		arst_n_i = 1'b0;
		ioctl    = '0;
		rd_addr  = '0;
		repeat (16) @(posedge clk_sys);
		#2;
		check_ce(ce, '0);
		check_bit("cart_loaded_o", loaded, 1'b0);
		arst_n_i = 1'b1;
		count_enables();
		load_cart(8'd0, 1024);
		check_bit("cart_loaded_o", loaded, 1'b1);
		probe_read(22'h5A3, 22'h1A3);
		probe_read(22'h3FF, 22'h3FF);
		if (!aborted) begin
			load_cart(8'd0, 1536);   // Image behind a copier header
			probe_read(22'h100, 22'h300);
		end
		if (!aborted)
			load_cheat();
		if (!aborted) begin
			load_cart(8'd2, 8);
			check_bit("is_gg_o", is_gg, 1'b1);
			load_cart(8'd1, 8);
			check_bit("is_gg_o", is_gg, 1'b0);
		end
		$display("Errors: %0d value, %0d protocol", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+hdl
hdl/sms_pkg.sv
hdl/clk_enable_gen.sv
hdl/rom_write_ctrl.sv
hdl/cart_geometry.sv
hdl/cheat_code_loader.sv
hdl/sms_cart_loader.sv
testbench/tb_sms_cart_loader.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cart loader testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_sms_cart_loader -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
